/* hdl/collision_pkg.sv */
package collision_pkg;

    // map coordinates and Q8.4 velocities
    localparam int POS_W      = 10;
    localparam int VEL_INT_W  = 8;
    localparam int VEL_FRAC_W = 4;
    localparam int VEL_W      = VEL_INT_W + VEL_FRAC_W;

    localparam int RAD_W  = 6;
    // effective mass is the level plus one
    localparam int MASS_W = 3;

    // heading in whole degrees
    localparam int ANG_W = 10;

    // vx*vx + vy*vy of one car
    localparam int SQ_W = 26;

    localparam int CORDIC_ITERS = 12;

    typedef logic signed [POS_W-1:0] pos_t;
    typedef logic signed [VEL_W-1:0] vel_t;
    typedef logic        [RAD_W-1:0] rad_t;
    typedef logic       [MASS_W-1:0] mass_t;
    typedef logic        [ANG_W-1:0] ang_t;
    typedef logic         [SQ_W-1:0] sq_t;

    typedef enum logic [1:0] {
        IDLE,
        LAUNCH,
        MEASURE,
        DONE
    } ctrl_state_t;

endpackage

/* hdl/collision_velocity.sv */
module collision_velocity (
    input  collision_pkg::pos_t  i_car1_x, i_car1_y, i_car2_x, i_car2_y,
    input  collision_pkg::vel_t  i_car1_vx, i_car1_vy, i_car2_vx, i_car2_vy,
    input  collision_pkg::rad_t  i_car1_radius, i_car2_radius,
    input  collision_pkg::mass_t i_car1_mass, i_car2_mass,
    output collision_pkg::vel_t  o_car1_vx, o_car1_vy, o_car2_vx, o_car2_vy,
    output logic                 o_collision
);

    logic signed [collision_pkg::POS_W:0] rel_x;
    logic signed [collision_pkg::POS_W:0] rel_y;
    logic signed [collision_pkg::VEL_W:0] rel_vx;
    logic signed [collision_pkg::VEL_W:0] rel_vy;
    logic        [collision_pkg::RAD_W:0] rad_sum;

    logic signed [63:0] dist_sq;
    logic signed [63:0] reach_sq;
    logic signed [63:0] dot;
    logic signed [63:0] m1;
    logic signed [63:0] m2;
    logic signed [63:0] scale;
    logic signed [63:0] divisor;
    logic signed [63:0] q1x;
    logic signed [63:0] q1y;
    logic signed [63:0] q2x;
    logic signed [63:0] q2y;

    // car 1 relative to car 2
    assign rel_x  = i_car1_x - i_car2_x;
    assign rel_y  = i_car1_y - i_car2_y;
    assign rel_vx = i_car1_vx - i_car2_vx;
    assign rel_vy = i_car1_vy - i_car2_vy;

    assign rad_sum  = i_car1_radius + i_car2_radius;
    assign dist_sq  = rel_x * rel_x + rel_y * rel_y;
    assign reach_sq = $signed({1'b0, rad_sum}) * $signed({1'b0, rad_sum});
    assign dot      = rel_vx * rel_x + rel_vy * rel_y;

    assign m1 = 64'sd1 + $signed({1'b0, i_car1_mass});
    assign m2 = 64'sd1 + $signed({1'b0, i_car2_mass});

    // common denominator (m1 + m2) * |d|^2
    assign scale = (m1 + m2) * dist_sq;

    // overlapping and closing in
    assign o_collision = (dist_sq <= reach_sq) && (dot < 0);

    // coincident centres give dot == 0, so no collision and a unit divisor
    assign divisor = o_collision ? scale : 64'sd1;

    // signed division truncates toward zero
    assign q1x = (scale * i_car1_vx - 64'sd2 * m2 * dot * rel_x) / divisor;
    assign q1y = (scale * i_car1_vy - 64'sd2 * m2 * dot * rel_y) / divisor;
    assign q2x = (scale * i_car2_vx + 64'sd2 * m1 * dot * rel_x) / divisor;
    assign q2y = (scale * i_car2_vy + 64'sd2 * m1 * dot * rel_y) / divisor;

    assign o_car1_vx = o_collision ? q1x[collision_pkg::VEL_W-1:0] : i_car1_vx;
    assign o_car1_vy = o_collision ? q1y[collision_pkg::VEL_W-1:0] : i_car1_vy;
    assign o_car2_vx = o_collision ? q2x[collision_pkg::VEL_W-1:0] : i_car2_vx;
    assign o_car2_vy = o_collision ? q2y[collision_pkg::VEL_W-1:0] : i_car2_vy;

endmodule

/* hdl/speed_sqrt.sv */
module speed_sqrt (
    input  logic                car1_after_collision_angle_done,
    input  logic                i_rst_n,
    input  logic                i_start,
    input  collision_pkg::sq_t  i_rad,
    output collision_pkg::vel_t o_root,
    output logic                o_valid
);

    collision_pkg::sq_t                       rad_q;
    logic [collision_pkg::SQ_W/2+1:0]         rem_q;
    logic [collision_pkg::SQ_W/2+1:0]         rem_d;
    logic [collision_pkg::SQ_W/2+3:0]         trial;
    logic [collision_pkg::SQ_W/2-1:0]         root_q;
    logic [collision_pkg::SQ_W/2-1:0]         root_d;
    logic [$clog2(collision_pkg::SQ_W/2)-1:0] cnt;
    logic                                     busy;
    logic                                     sat;

    // one root bit per step from the top two radicand bits
    always_comb begin
        trial = {rem_q, rad_q[collision_pkg::SQ_W-1 -: 2]} - {2'b00, root_q, 2'b01};
        if (!trial[collision_pkg::SQ_W/2+3]) begin
            rem_d  = trial[collision_pkg::SQ_W/2+1:0];
            root_d = {root_q[collision_pkg::SQ_W/2-2:0], 1'b1};
        end else begin
            rem_d  = {rem_q[collision_pkg::SQ_W/2-1:0], rad_q[collision_pkg::SQ_W-1 -: 2]};
            root_d = {root_q[collision_pkg::SQ_W/2-2:0], 1'b0};
        end
        sat = root_d > (2 ** (collision_pkg::VEL_W - 1)) - 1;
    end

    always_ff @(posedge car1_after_collision_angle_done) begin
        if (i_start) begin
            rad_q  <= i_rad;
            rem_q  <= '0;
            root_q <= '0;
        end else if (busy) begin
            rad_q  <= rad_q << 2;
            rem_q  <= rem_d;
            root_q <= root_d;
        end
    end

    always_ff @(posedge car1_after_collision_angle_done or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy    <= 1'b0;
            cnt     <= '0;
            o_valid <= 1'b0;
            o_root  <= '0;
        end else begin
            o_valid <= 1'b0;
            if (i_start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == collision_pkg::SQ_W/2 - 1) begin
                    busy    <= 1'b0;
                    o_valid <= 1'b1;
                    // clamp to the largest Q8.4 value
                    o_root  <= sat ? {1'b0, {(collision_pkg::VEL_W-1){1'b1}}}
                                   : root_d[collision_pkg::VEL_W-1:0];
                end
            end
        end
    end

endmodule

/* hdl/heading_cordic.sv */
module heading_cordic (
    input  logic                car1_after_collision_angle_done,
    input  logic                i_rst_n,
    input  logic                i_start,
    input  collision_pkg::vel_t i_x,
    input  collision_pkg::vel_t i_y,
    output collision_pkg::ang_t o_angle,
    output logic                o_done
);

    // two guard bits below the Q8.4 lsb
    logic signed [collision_pkg::VEL_W+3:0]                 x_q;
    logic signed [collision_pkg::VEL_W+3:0]                 y_q;
    // angle accumulator, degrees with 8 fraction bits
    logic signed [collision_pkg::ANG_W+7:0]                 z_q;
    logic signed [collision_pkg::ANG_W+7:0]                 z_round;
    logic signed [collision_pkg::ANG_W-1:0]                 deg;
    collision_pkg::ang_t                                    heading;
    logic                                                   zero_q;
    logic                                                   busy;
    logic [$clog2(collision_pkg::CORDIC_ITERS+1)-1:0]       cnt;

    // atan(2^-i) in degrees, scaled by 256
    function automatic logic signed [collision_pkg::ANG_W+7:0] atan_deg(
        input logic [$clog2(collision_pkg::CORDIC_ITERS+1)-1:0] idx
    );
        case (idx)
            'd0:     return 11520;
            'd1:     return 6801;
            'd2:     return 3593;
            'd3:     return 1824;
            'd4:     return 916;
            'd5:     return 458;
            'd6:     return 229;
            'd7:     return 115;
            'd8:     return 57;
            'd9:     return 29;
            'd10:    return 14;
            'd11:    return 7;
            default: return 0;
        endcase
    endfunction

    always_ff @(posedge car1_after_collision_angle_done) begin
        if (i_start) begin
            zero_q <= (i_x == '0) && (i_y == '0);
            // left half-plane vectors are turned by 180 degrees first
            if (i_x < 0) begin
                x_q <= -$signed({i_x, 2'b00});
                y_q <= -$signed({i_y, 2'b00});
                z_q <= 180 * 256;
            end else begin
                x_q <= $signed({i_x, 2'b00});
                y_q <= $signed({i_y, 2'b00});
                z_q <= '0;
            end
        end else if (busy && cnt < collision_pkg::CORDIC_ITERS) begin
            // rotate toward the x axis, summing the angle removed
            if (!y_q[collision_pkg::VEL_W+3]) begin
                x_q <= x_q + (y_q >>> cnt);
                y_q <= y_q - (x_q >>> cnt);
                z_q <= z_q + atan_deg(cnt);
            end else begin
                x_q <= x_q - (y_q >>> cnt);
                y_q <= y_q + (x_q >>> cnt);
                z_q <= z_q - atan_deg(cnt);
            end
        end
    end

    // round to whole degrees, then fold negatives into 0..359
    assign z_round = z_q + 128;
    assign deg     = z_round[collision_pkg::ANG_W+7:8];
    assign heading = deg[collision_pkg::ANG_W-1] ? deg + 10'd360 : deg;

    always_ff @(posedge car1_after_collision_angle_done or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy    <= 1'b0;
            cnt     <= '0;
            o_done  <= 1'b0;
            o_angle <= '0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                if (cnt == collision_pkg::CORDIC_ITERS) begin
                    busy    <= 1'b0;
                    o_done  <= 1'b1;
                    o_angle <= zero_q ? '0 : heading;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* hdl/collision_ctrl.sv */
module collision_ctrl (
    input  logic                car1_after_collision_angle_done,
    input  logic                i_rst_n,
    input  logic                i_start,
    input  logic                i_collision,
    input  collision_pkg::vel_t i_car1_vx, i_car1_vy, i_car2_vx, i_car2_vy,
    input  collision_pkg::vel_t i_car1_speed, i_car2_speed,
    input  logic                i_speed1_valid, i_speed2_valid,
    input  collision_pkg::ang_t i_car1_angle, i_car2_angle,
    input  logic                i_angle1_done, i_angle2_done,
    output logic                o_meas_start,
    output collision_pkg::sq_t  o_car1_rad, o_car2_rad,
    output collision_pkg::vel_t o_car1_vx, o_car1_vy, o_car2_vx, o_car2_vy,
    output collision_pkg::vel_t o_car1_speed, o_car2_speed,
    output collision_pkg::ang_t o_car1_angle, o_car2_angle,
    output logic                o_collision,
    output logic                o_busy,
    output logic                o_done
);

    collision_pkg::ctrl_state_t state;
    logic [3:0]                 seen_q;
    logic [3:0]                 seen_d;

    // radicands come from the latched velocities
    assign o_car1_rad = o_car1_vx * o_car1_vx + o_car1_vy * o_car1_vy;
    assign o_car2_rad = o_car2_vx * o_car2_vx + o_car2_vy * o_car2_vy;

    // completions seen so far, including this cycle
    assign seen_d = seen_q | {i_angle2_done, i_angle1_done, i_speed2_valid, i_speed1_valid};

    assign o_busy = (state != collision_pkg::IDLE);
    assign o_done = (state == collision_pkg::DONE);

    always_ff @(posedge car1_after_collision_angle_done or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= collision_pkg::IDLE;
            seen_q       <= '0;
            o_meas_start <= 1'b0;
            o_collision  <= 1'b0;
            o_car1_vx    <= '0;
            o_car1_vy    <= '0;
            o_car2_vx    <= '0;
            o_car2_vy    <= '0;
            o_car1_speed <= '0;
            o_car2_speed <= '0;
            o_car1_angle <= '0;
            o_car2_angle <= '0;
        end else begin
            o_meas_start <= 1'b0;
            case (state)
                collision_pkg::IDLE: begin
                    if (i_start) state <= collision_pkg::LAUNCH;
                end
                collision_pkg::LAUNCH: begin
                    o_collision  <= i_collision;
                    o_car1_vx    <= i_car1_vx;
                    o_car1_vy    <= i_car1_vy;
                    o_car2_vx    <= i_car2_vx;
                    o_car2_vy    <= i_car2_vy;
                    seen_q       <= '0;
                    o_meas_start <= 1'b1;
                    state        <= collision_pkg::MEASURE;
                end
                collision_pkg::MEASURE: begin
                    seen_q <= seen_d;
                    if (i_speed1_valid) o_car1_speed <= i_car1_speed;
                    if (i_speed2_valid) o_car2_speed <= i_car2_speed;
                    if (i_angle1_done) o_car1_angle <= i_car1_angle;
                    if (i_angle2_done) o_car2_angle <= i_car2_angle;
                    if (&seen_d) state <= collision_pkg::DONE;
                end
                collision_pkg::DONE: begin
                    state <= collision_pkg::IDLE;
                end
                default: state <= collision_pkg::IDLE;
            endcase
        end
    end

endmodule

/* hdl/car_collision.sv */
module car_collision (
    input  logic                 car1_after_collision_angle_done,
    input  logic                 i_rst_n,
    input  logic                 i_start,
    input  collision_pkg::pos_t  i_car1_x, i_car1_y, i_car2_x, i_car2_y,
    input  collision_pkg::vel_t  i_car1_vx, i_car1_vy, i_car2_vx, i_car2_vy,
    input  collision_pkg::rad_t  i_car1_radius, i_car2_radius,
    input  collision_pkg::mass_t i_car1_mass, i_car2_mass,
    output collision_pkg::vel_t  o_car1_vx, o_car1_vy, o_car2_vx, o_car2_vy,
    output collision_pkg::vel_t  o_car1_speed, o_car2_speed,
    output collision_pkg::ang_t  o_car1_angle, o_car2_angle,
    output logic                 o_collision,
    output logic                 o_busy,
    output logic                 o_done
);

    collision_pkg::vel_t new_car1_vx, new_car1_vy, new_car2_vx, new_car2_vy;
    collision_pkg::vel_t speed1, speed2;
    collision_pkg::ang_t angle1, angle2;
    collision_pkg::sq_t  rad1, rad2;
    logic                hit;
    logic                meas_start;
    logic                speed1_valid, speed2_valid;
    logic                angle1_done, angle2_done;

    collision_velocity u_velocity (
        .i_car1_x      (i_car1_x),      .i_car1_y      (i_car1_y),
        .i_car2_x      (i_car2_x),      .i_car2_y      (i_car2_y),
        .i_car1_vx     (i_car1_vx),     .i_car1_vy     (i_car1_vy),
        .i_car2_vx     (i_car2_vx),     .i_car2_vy     (i_car2_vy),
        .i_car1_radius (i_car1_radius), .i_car2_radius (i_car2_radius),
        .i_car1_mass   (i_car1_mass),   .i_car2_mass   (i_car2_mass),
        .o_car1_vx     (new_car1_vx),   .o_car1_vy     (new_car1_vy),
        .o_car2_vx     (new_car2_vx),   .o_car2_vy     (new_car2_vy),
        .o_collision   (hit)
    );

    collision_ctrl u_ctrl (
        .car1_after_collision_angle_done (car1_after_collision_angle_done),
        .i_rst_n        (i_rst_n),
        .i_start        (i_start),
        .i_collision    (hit),
        .i_car1_vx      (new_car1_vx),  .i_car1_vy      (new_car1_vy),
        .i_car2_vx      (new_car2_vx),  .i_car2_vy      (new_car2_vy),
        .i_car1_speed   (speed1),       .i_car2_speed   (speed2),
        .i_speed1_valid (speed1_valid), .i_speed2_valid (speed2_valid),
        .i_car1_angle   (angle1),       .i_car2_angle   (angle2),
        .i_angle1_done  (angle1_done),  .i_angle2_done  (angle2_done),
        .o_meas_start   (meas_start),
        .o_car1_rad     (rad1),         .o_car2_rad     (rad2),
        .o_car1_vx      (o_car1_vx),    .o_car1_vy      (o_car1_vy),
        .o_car2_vx      (o_car2_vx),    .o_car2_vy      (o_car2_vy),
        .o_car1_speed   (o_car1_speed), .o_car2_speed   (o_car2_speed),
        .o_car1_angle   (o_car1_angle), .o_car2_angle   (o_car2_angle),
        .o_collision    (o_collision),
        .o_busy         (o_busy),
        .o_done         (o_done)
    );

    speed_sqrt u_speed1 (
        .car1_after_collision_angle_done (car1_after_collision_angle_done),
        .i_rst_n (i_rst_n), .i_start (meas_start), .i_rad (rad1),
        .o_root  (speed1),  .o_valid (speed1_valid)
    );

    speed_sqrt u_speed2 (
        .car1_after_collision_angle_done (car1_after_collision_angle_done),
        .i_rst_n (i_rst_n), .i_start (meas_start), .i_rad (rad2),
        .o_root  (speed2),  .o_valid (speed2_valid)
    );

    // headings use the latched post-collision vectors
    heading_cordic u_heading1 (
        .car1_after_collision_angle_done (car1_after_collision_angle_done),
        .i_rst_n (i_rst_n), .i_start (meas_start),
        .i_x     (o_car1_vx), .i_y (o_car1_vy),
        .o_angle (angle1),    .o_done (angle1_done)
    );

    heading_cordic u_heading2 (
        .car1_after_collision_angle_done (car1_after_collision_angle_done),
        .i_rst_n (i_rst_n), .i_start (meas_start),
        .i_x     (o_car2_vx), .i_y (o_car2_vy),
        .o_angle (angle2),    .o_done (angle2_done)
    );

endmodule

/* verif/car_collision_assertions.sv */
module car_collision_assertions (
    input logic car1_after_collision_angle_done,
    input logic i_rst_n,
    input logic i_start,
    input logic o_busy,
    input logic o_done
);

    timeunit 1ns;
    timeprecision 1ps;

    int   failures = 0;
    logic pending;

    // an accepted request stays outstanding until its done pulse
    always_ff @(posedge car1_after_collision_angle_done or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pending <= 1'b0;
        end else if (o_done) begin
            pending <= 1'b0;
        end else if (i_start && !o_busy) begin
            pending <= 1'b1;
        end
    end

    done_one_cycle: assert property (@(posedge car1_after_collision_angle_done)
        disable iff (!i_rst_n) o_done |=> !o_done)
        else begin
            $error("o_done held for more than one cycle");
            failures++;
        end

    busy_falls_after_done: assert property (@(posedge car1_after_collision_angle_done)
        disable iff (!i_rst_n) o_done |=> !o_busy)
        else begin
            $error("o_busy still high on the cycle after o_done");
            failures++;
        end

    done_needs_start: assert property (@(posedge car1_after_collision_angle_done)
        disable iff (!i_rst_n) o_done |-> pending)
        else begin
            $error("o_done without an accepted i_start");
            failures++;
        end

endmodule

bind car_collision car_collision_assertions u_assertions (
    .car1_after_collision_angle_done (car1_after_collision_angle_done),
    .i_rst_n                         (i_rst_n),
    .i_start                         (i_start),
    .o_busy                          (o_busy),
    .o_done                          (o_done)
);

/* verif/car_collision_tb.sv */
module car_collision_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CASES    = 10;
    localparam int COLS         = 13;
    localparam int NUM_RANDOM   = 4;
    localparam int DONE_TIMEOUT = 200;

    logic                 car1_after_collision_angle_done = 1'b0;
    logic                 i_rst_n;
    logic                 i_start;
    collision_pkg::pos_t  i_car1_x, i_car1_y, i_car2_x, i_car2_y;
    collision_pkg::vel_t  i_car1_vx, i_car1_vy, i_car2_vx, i_car2_vy;
    collision_pkg::rad_t  i_car1_radius, i_car2_radius;
    collision_pkg::mass_t i_car1_mass, i_car2_mass;
    collision_pkg::vel_t  o_car1_vx, o_car1_vy, o_car2_vx, o_car2_vy;
    collision_pkg::vel_t  o_car1_speed, o_car2_speed;
    collision_pkg::ang_t  o_car1_angle, o_car2_angle;
    logic                 o_collision;
    logic                 o_busy;
    logic                 o_done;

    collision_pkg::vel_t  exp_v1x, exp_v1y, exp_v2x, exp_v2y;
    bit                   exp_hit;
    int                   seed;
    int                   error_count = 0;
    int                   pass_count = 0;
    int                   fail_count = 0;
    bit                   stop_run = 1'b0;

    // columns: car1 x, car1 y, car2 x, car2 y, car1 vx, car1 vy, car2 vx, car2 vy,
    // radius1, radius2, mass1, mass2, expected collision (velocities in raw Q8.4)
    int case_tbl [NUM_CASES][COLS] = '{
        '{   0,    0,  20,   0,   32,     0,   -32,    0, 12, 12, 0, 0, 1},
        '{   0,    0,  12,  16,   48,    16,   -16,  -32, 12, 12, 1, 1, 1},
        '{   0,    0,  20,   0,  -32,     8,    32,    0, 12, 12, 0, 0, 0},
        '{-300, -200, 300, 250,    0,   -40,   -40,    0, 20, 20, 2, 3, 0},
        '{  10,   -5,  25,   3,   40,    10,   -20,  -30, 10,  9, 6, 1, 1},
        '{ 100,  100,  90, 108,  -50,    24,    30,  -10,  8,  8, 0, 7, 1},
        '{-400,    0, 400,   0,    0,     0,   -24,  -24, 30, 30, 3, 3, 0},
        '{-100,  300, 200, -300, -30,    52,    45,  -26,  5,  5, 1, 2, 0},
        '{   0, -400,   0, 400,    0,    64,    64,   64, 40, 40, 4, 4, 0},
        '{-450, -450, 450, 450, 2000, -2000, -2048,  100, 63, 63, 7, 7, 0}
    };

    string case_name [NUM_CASES] = '{
        "head_on_equal", "oblique_equal", "separating", "distant", "unequal_mass",
        "heavy_car2", "zero_vector", "quadrants", "axes", "saturation"
    };

    car_collision DUT (.*);

    always #20 car1_after_collision_angle_done = ~car1_after_collision_angle_done;

    task automatic report_mismatch(input string name, input string field,
                                   input int expected, input int actual);
        error_count++;
        $display("[ERROR] %s %s: expected %0d, actual %0d", name, field, expected, actual);
    endtask

    task automatic close_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            pass_count++;
            $display("test %-18s ok", name);
        end else begin
            fail_count++;
            $display("test %-18s %0d mismatches", name, error_count - errs_before);
        end
    endtask

    // elastic two-body exchange along the line of centres
    task automatic compute_expected();
        longint dx, dy, dvx, dvy;
        longint d2, reach, dot, m1, m2, den;
        dx    = longint'(i_car1_x) - longint'(i_car2_x);
        dy    = longint'(i_car1_y) - longint'(i_car2_y);
        dvx   = longint'(i_car1_vx) - longint'(i_car2_vx);
        dvy   = longint'(i_car1_vy) - longint'(i_car2_vy);
        d2    = dx * dx + dy * dy;
        reach = longint'(i_car1_radius) + longint'(i_car2_radius);
        dot   = dvx * dx + dvy * dy;
        m1    = longint'(i_car1_mass) + 1;
        m2    = longint'(i_car2_mass) + 1;
        exp_hit = (d2 <= reach * reach) && (dot < 0);
        exp_v1x = i_car1_vx;
        exp_v1y = i_car1_vy;
        exp_v2x = i_car2_vx;
        exp_v2y = i_car2_vy;
        if (exp_hit) begin
            den = (m1 + m2) * d2;
            exp_v1x = collision_pkg::vel_t'((den * i_car1_vx - 2 * m2 * dot * dx) / den);
            exp_v1y = collision_pkg::vel_t'((den * i_car1_vy - 2 * m2 * dot * dy) / den);
            exp_v2x = collision_pkg::vel_t'((den * i_car2_vx + 2 * m1 * dot * dx) / den);
            exp_v2y = collision_pkg::vel_t'((den * i_car2_vy + 2 * m1 * dot * dy) / den);
        end
    endtask

    function automatic int speed_ref(input int x, input int y);
        longint sum;
        longint r;
        sum = longint'(x) * x + longint'(y) * y;
        r = 0;
        while ((r + 1) * (r + 1) <= sum) r++;
        if (r > (1 << (collision_pkg::VEL_W - 1)) - 1) r = (1 << (collision_pkg::VEL_W - 1)) - 1;
        return int'(r);
    endfunction

    function automatic real ref_heading(input int x, input int y);
        real deg;
        deg = $atan2(real'(y), real'(x)) * 180.0 / 3.141592653589793;
        if (deg < 0.0) deg = deg + 360.0;
        return deg;
    endfunction

    function automatic bit heading_matches(input int x, input int y, input int act);
        real diff;
        if (x == 0 && y == 0) return act == 0;
        diff = real'(act) - ref_heading(x, y);
        if (diff > 180.0) diff = diff - 360.0;
        if (diff < -180.0) diff = diff + 360.0;
        return (diff <= 2.0) && (diff >= -2.0);
    endfunction

    task automatic check_results(input string name, input bit exp_flag);
        if (o_collision !== exp_flag) report_mismatch(name, "collision", exp_flag, o_collision);
        if (o_car1_vx !== exp_v1x) report_mismatch(name, "car1_vx", exp_v1x, o_car1_vx);
        if (o_car1_vy !== exp_v1y) report_mismatch(name, "car1_vy", exp_v1y, o_car1_vy);
        if (o_car2_vx !== exp_v2x) report_mismatch(name, "car2_vx", exp_v2x, o_car2_vx);
        if (o_car2_vy !== exp_v2y) report_mismatch(name, "car2_vy", exp_v2y, o_car2_vy);
        if (o_car1_speed !== speed_ref(exp_v1x, exp_v1y))
            report_mismatch(name, "car1_speed", speed_ref(exp_v1x, exp_v1y), o_car1_speed);
        if (o_car2_speed !== speed_ref(exp_v2x, exp_v2y))
            report_mismatch(name, "car2_speed", speed_ref(exp_v2x, exp_v2y), o_car2_speed);
        if (!heading_matches(exp_v1x, exp_v1y, o_car1_angle))
            report_mismatch(name, "car1_angle",
                            $rtoi(ref_heading(exp_v1x, exp_v1y) + 0.5) % 360, o_car1_angle);
        if (!heading_matches(exp_v2x, exp_v2y, o_car2_angle))
            report_mismatch(name, "car2_angle",
                            $rtoi(ref_heading(exp_v2x, exp_v2y) + 0.5) % 360, o_car2_angle);
    endtask

    task automatic wait_done(output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < DONE_TIMEOUT && !ok; n++) begin
            @(negedge car1_after_collision_angle_done);
            if (o_done) ok = 1'b1;
        end
    endtask

    // pulse i_start, wait for o_done and compare against the model
    task automatic run_case(input string name, input bit exp_flag);
        bit ok;
        int errs_before;
        errs_before = error_count;
        i_start = 1'b1;
        @(negedge car1_after_collision_angle_done);
        i_start = 1'b0;
        wait_done(ok);
        if (!ok) begin
            $display("test %s: o_done did not arrive within %0d cycles", name, DONE_TIMEOUT);
            error_count++;
            stop_run = 1'b1;
        end else begin
            check_results(name, exp_flag);
        end
        close_test(name, errs_before);
    endtask

    task automatic load_row(input int r);
        i_car1_x      = collision_pkg::pos_t'(case_tbl[r][0]);
        i_car1_y      = collision_pkg::pos_t'(case_tbl[r][1]);
        i_car2_x      = collision_pkg::pos_t'(case_tbl[r][2]);
        i_car2_y      = collision_pkg::pos_t'(case_tbl[r][3]);
        i_car1_vx     = collision_pkg::vel_t'(case_tbl[r][4]);
        i_car1_vy     = collision_pkg::vel_t'(case_tbl[r][5]);
        i_car2_vx     = collision_pkg::vel_t'(case_tbl[r][6]);
        i_car2_vy     = collision_pkg::vel_t'(case_tbl[r][7]);
        i_car1_radius = collision_pkg::rad_t'(case_tbl[r][8]);
        i_car2_radius = collision_pkg::rad_t'(case_tbl[r][9]);
        i_car1_mass   = collision_pkg::mass_t'(case_tbl[r][10]);
        i_car2_mass   = collision_pkg::mass_t'(case_tbl[r][11]);
    endtask

    // keep random vectors long enough for a meaningful heading
    task automatic random_velocity(output int vx, output int vy);
        vx = $random(seed) % 1500;
        vy = $random(seed) % 1500;
        if ((vx < 0 ? -vx : vx) + (vy < 0 ? -vy : vy) < 64) vx = 100;
    endtask

    // cars stay 300 apart in x, so no overlap
    task automatic draw_random_case();
        int c1x;
        int vx;
        int vy;
        c1x = $random(seed) % 150;
        i_car1_x = collision_pkg::pos_t'(c1x);
        i_car2_x = collision_pkg::pos_t'(c1x + 300);
        i_car1_y = collision_pkg::pos_t'($random(seed) % 400);
        i_car2_y = collision_pkg::pos_t'($random(seed) % 400);
        random_velocity(vx, vy);
        i_car1_vx = collision_pkg::vel_t'(vx);
        i_car1_vy = collision_pkg::vel_t'(vy);
        random_velocity(vx, vy);
        i_car2_vx = collision_pkg::vel_t'(vx);
        i_car2_vy = collision_pkg::vel_t'(vy);
        i_car1_radius = collision_pkg::rad_t'($random(seed));
        i_car2_radius = collision_pkg::rad_t'($random(seed));
        i_car1_mass   = collision_pkg::mass_t'($random(seed));
        i_car2_mass   = collision_pkg::mass_t'($random(seed));
    endtask

    // a second start while busy must not produce a second done
    task automatic check_start_while_busy();
        int errs_before;
        int n;
        int dones;
        errs_before = error_count;
        @(negedge car1_after_collision_angle_done);
        load_row(0);
        i_start = 1'b1;
        @(negedge car1_after_collision_angle_done);
        i_start = 1'b0;
        for (n = 0; n < 10 && !o_busy; n++) @(negedge car1_after_collision_angle_done);
        if (!o_busy) begin
            $display("test start_while_busy: o_busy never rose after i_start");
            error_count++;
        end else begin
            i_start = 1'b1;
            @(negedge car1_after_collision_angle_done);
            i_start = 1'b0;
            dones = 0;
            for (n = 0; n < DONE_TIMEOUT; n++) begin
                @(negedge car1_after_collision_angle_done);
                if (o_done) dones++;
            end
            if (dones != 1) report_mismatch("start_while_busy", "done_count", 1, dones);
            if (o_busy !== 1'b0) report_mismatch("start_while_busy", "o_busy", 0, o_busy);
        end
        close_test("start_while_busy", errs_before);
    endtask

    initial begin
        int i;
        int errs;
        seed    = 9;
        i_rst_n = 1'b0;
        i_start = 1'b0;
        load_row(0);
        repeat (8) @(negedge car1_after_collision_angle_done);
        i_rst_n = 1'b1;
        @(negedge car1_after_collision_angle_done);
        errs = error_count;
        if (o_busy !== 1'b0) report_mismatch("reset_state", "o_busy", 0, o_busy);
        if (o_done !== 1'b0) report_mismatch("reset_state", "o_done", 0, o_done);
        if (o_collision !== 1'b0) report_mismatch("reset_state", "collision", 0, o_collision);
        close_test("reset_state", errs);

        for (i = 0; i < NUM_CASES && !stop_run; i++) begin
            @(negedge car1_after_collision_angle_done);
            load_row(i);
            compute_expected();
            run_case(case_name[i], case_tbl[i][12] != 0);
        end
        for (i = 0; i < NUM_RANDOM && !stop_run; i++) begin
            @(negedge car1_after_collision_angle_done);
            draw_random_case();
            compute_expected();
            run_case($sformatf("random_%0d", i), exp_hit);
        end
        if (!stop_run) check_start_while_busy();

        $display("summary: %0d ok, %0d with errors, %0d mismatches, %0d assertion failures",
                 pass_count, fail_count, error_count, DUT.u_assertions.failures);
        if (error_count == 0 && fail_count == 0 && DUT.u_assertions.failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* sim.f */
hdl/collision_pkg.sv
hdl/collision_velocity.sv
hdl/speed_sqrt.sv
hdl/heading_cordic.sv
hdl/collision_ctrl.sv
hdl/car_collision.sv
verif/car_collision_assertions.sv
verif/car_collision_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= car_collision_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_ARGS) | tee $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
